/* logic/eth_pkg.sv */
package eth_pkg;

	// --------------------------------------------------
	// line-side framing constants
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hd5;
	localparam int PREAMBLE_LEN = 7;
	localparam int FCS_LEN = 4;
	localparam int IFG_CYCLES = 12;

	localparam logic [31:0] CRC_POLY = 32'h04c11db7;
	localparam logic [31:0] CRC_INIT = 32'hffffffff;
	localparam logic [31:0] CRC_RESIDUE = 32'hc704dd7b; // seen after a good FCS

	// shared by framer and deframer, each uses a subset
	typedef enum logic [2:0] {
		FS_IDLE,
		FS_PREAMBLE,
		FS_SFD,
		FS_DATA,
		FS_FCS,
		FS_GAP,
		FS_COMMIT
	} frame_state_t;

	// --------------------------------------------------
	// one byte through the crc register, d[0] goes in first
	function automatic logic [31:0] next_crc32_d8(input logic [7:0] data,
			input logic [31:0] crc);
		logic [31:0] c;
		logic fb;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			fb = c[31] ^ data[i];
			c = {c[30:0], 1'b0};
			if (fb)
				c = c ^ CRC_POLY;
		end
		return c;
	endfunction

	function automatic logic [7:0] reverse_byte(input logic [7:0] data);
		logic [7:0] r;
		for (int i = 0; i < 8; i++)
			r[i] = data[7 - i];
		return r;
	endfunction

endpackage

/* logic/host_pkg.sv */
package host_pkg;

	localparam int MAX_LEN = 64;
	localparam int BYTE_ADDR_W = $clog2(MAX_LEN);
	localparam int RING_DEPTH = 4; // one slot is always the fill slot

	typedef logic [7:0] byte_t;
	typedef logic [BYTE_ADDR_W:0] pkt_len_t; // holds 0 to MAX_LEN
	typedef logic [$clog2(RING_DEPTH)-1:0] slot_t;
	typedef logic [15:0] result_t;

	typedef enum logic [2:0] {
		OP_READ = 3'd0,
		OP_READ_LEN = 3'd1,
		OP_READ_NEXT = 3'd2,
		OP_WRITE = 3'd3,
		OP_WRITE_LEN = 3'd4,
		OP_WRITE_NEXT = 3'd5
	} host_op_t;

	// ring write side
	typedef enum logic [2:0] {
		WR_NONE,
		WR_BYTE,
		WR_LEN,
		WR_COMMIT,
		WR_TRIM,
		WR_CLEAR
	} wr_op_t;

	// ring read side
	typedef enum logic [1:0] {
		RD_NONE,
		RD_BYTE,
		RD_LEN,
		RD_RELEASE
	} rd_op_t;

endpackage

/* logic/packet_ring.sv */
module packet_ring (
	input  logic clock,
	input  logic reset,
	input  host_pkg::wr_op_t wr_op_i,
	input  host_pkg::pkt_len_t wr_addr_i,
	input  host_pkg::byte_t wr_data_i,
	output host_pkg::result_t wr_result_o,
	input  host_pkg::rd_op_t rd_op_i,
	input  host_pkg::pkt_len_t rd_addr_i,
	output host_pkg::result_t rd_result_o,
	output logic rd_avail_o
);
	import host_pkg::*;
	import eth_pkg::*;

	byte_t mem [RING_DEPTH][MAX_LEN];
	pkt_len_t len [RING_DEPTH];
	slot_t fill_ptr; // slot being written
	slot_t head_ptr; // oldest committed slot
	slot_t next_fill;
	logic [$clog2(RING_DEPTH)-1:0] count;
	logic commit_ok;
	logic release_ok;

	assign next_fill = fill_ptr + 1'b1;
	assign commit_ok = (wr_op_i == WR_COMMIT) && (len[fill_ptr] != '0) &&
		(count < RING_DEPTH - 1);
	assign release_ok = (rd_op_i == RD_RELEASE) && (count != '0);
	assign rd_avail_o = (count != '0);

	always_ff @(posedge clock) begin
		if (wr_op_i == WR_BYTE && wr_addr_i < MAX_LEN)
			mem[fill_ptr][wr_addr_i[BYTE_ADDR_W-1:0]] <= wr_data_i;
	end

	// --------------------------------------------------
	// write side, lengths and commit count
	always_ff @(posedge clock) begin
		if (reset) begin
			fill_ptr <= '0;
			count <= '0;
			wr_result_o <= '0;
			for (int i = 0; i < RING_DEPTH; i++)
				len[i] <= '0;
		end else begin
			case (wr_op_i)
				WR_BYTE: begin
					if (wr_addr_i < MAX_LEN) begin
						if (wr_addr_i >= len[fill_ptr])
							len[fill_ptr] <= wr_addr_i + 1'b1;
						wr_result_o <= '0;
					end else begin
						wr_result_o <= result_t'(1); // past end of slot
					end
				end
				WR_LEN: wr_result_o <= result_t'(len[fill_ptr]);
				WR_COMMIT: begin
					if (commit_ok) begin
						fill_ptr <= next_fill;
						len[next_fill] <= '0;
					end
					// empty slot is not an error, only a full ring
					wr_result_o <= result_t'(len[fill_ptr] != '0 && !commit_ok);
				end
				WR_TRIM: begin
					if (len[fill_ptr] >= FCS_LEN)
						len[fill_ptr] <= len[fill_ptr] - pkt_len_t'(FCS_LEN);
					wr_result_o <= '0;
				end
				WR_CLEAR: begin
					len[fill_ptr] <= '0;
					wr_result_o <= '0;
				end
				default: ;
			endcase

			if (commit_ok && !release_ok)
				count <= count + 1'b1;
			else if (release_ok && !commit_ok)
				count <= count - 1'b1;
		end
	end

	// --------------------------------------------------
	// read side
	always_ff @(posedge clock) begin
		if (reset) begin
			head_ptr <= '0;
			rd_result_o <= '0;
		end else begin
			case (rd_op_i)
				RD_BYTE: begin
					if (count != '0 && rd_addr_i < len[head_ptr])
						rd_result_o <= result_t'(mem[head_ptr][rd_addr_i[BYTE_ADDR_W-1:0]]);
					else
						rd_result_o <= '0;
				end
				RD_LEN: rd_result_o <= (count != '0) ? result_t'(len[head_ptr]) : '0;
				RD_RELEASE: begin
					if (release_ok)
						head_ptr <= head_ptr + 1'b1;
					rd_result_o <= result_t'(!release_ok); // 1 when nothing to free
				end
				default: ;
			endcase
		end
	end

endmodule

/* logic/host_port.sv */
module host_port (
	input  logic clock,
	input  logic reset,
	input  logic req_i,
	input  host_pkg::host_op_t op_i,
	input  host_pkg::pkt_len_t addr_i,
	input  host_pkg::byte_t value_i,
	output logic ack_o,
	output host_pkg::result_t result_o,
	output host_pkg::wr_op_t tx_wr_op_o,
	output host_pkg::pkt_len_t tx_wr_addr_o,
	output host_pkg::byte_t tx_wr_data_o,
	input  host_pkg::result_t tx_wr_result_i,
	output host_pkg::rd_op_t rx_rd_op_o,
	output host_pkg::pkt_len_t rx_rd_addr_o,
	input  host_pkg::result_t rx_rd_result_i
);
	import host_pkg::*;

	typedef enum logic [2:0] {
		HP_IDLE,
		HP_ISSUE,
		HP_EXEC,
		HP_CAPTURE,
		HP_HOLD,
		HP_RELEASE
	} port_state_t;

	port_state_t state;
	logic tx_sel; // result comes from the tx ring

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= HP_IDLE;
			ack_o <= 1'b0;
			result_o <= '0;
			tx_sel <= 1'b0;
			tx_wr_op_o <= WR_NONE;
			rx_rd_op_o <= RD_NONE;
		end else begin
			tx_wr_op_o <= WR_NONE; // ring ops last one cycle
			rx_rd_op_o <= RD_NONE;
			case (state)
				HP_IDLE: if (req_i && !ack_o) state <= HP_ISSUE;
				HP_ISSUE: begin
					tx_sel <= op_i inside {OP_WRITE, OP_WRITE_LEN, OP_WRITE_NEXT};
					case (op_i)
						OP_READ: rx_rd_op_o <= RD_BYTE;
						OP_READ_LEN: rx_rd_op_o <= RD_LEN;
						OP_READ_NEXT: rx_rd_op_o <= RD_RELEASE;
						OP_WRITE: tx_wr_op_o <= WR_BYTE;
						OP_WRITE_LEN: tx_wr_op_o <= WR_LEN;
						OP_WRITE_NEXT: tx_wr_op_o <= WR_COMMIT;
						default: ;
					endcase
					state <= HP_EXEC;
				end
				HP_EXEC: state <= HP_CAPTURE; // ring registers its result here
				HP_CAPTURE: begin
					result_o <= tx_sel ? tx_wr_result_i : rx_rd_result_i;
					ack_o <= 1'b1;
					state <= HP_HOLD;
				end
				HP_HOLD: if (!req_i) state <= HP_RELEASE;
				HP_RELEASE: begin
					ack_o <= 1'b0;
					state <= HP_IDLE;
				end
				default: state <= HP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == HP_ISSUE) begin
			tx_wr_addr_o <= addr_i;
			tx_wr_data_o <= value_i;
			rx_rd_addr_o <= addr_i;
		end
	end

endmodule

/* logic/tx_framer.sv */
module tx_framer (
	input  logic clock,
	input  logic reset,
	input  logic rd_avail_i,
	output host_pkg::rd_op_t rd_op_o,
	output host_pkg::pkt_len_t rd_addr_o,
	input  host_pkg::result_t rd_result_i,
	output host_pkg::byte_t tx_data_o,
	output logic tx_en_o
);
	import host_pkg::*;
	import eth_pkg::*;

	frame_state_t state;
	logic [3:0] cnt;
	pkt_len_t addr; // read address, one ahead of the wire
	pkt_len_t len;
	logic [31:0] crc;
	logic data_end;
	byte_t payload;
	byte_t tx_byte;

	assign payload = rd_result_i[$bits(byte_t)-1:0];
	assign data_end = (addr == len + 1'b1);
	assign rd_addr_o = addr;

	always_comb begin
		rd_op_o = RD_NONE;
		tx_byte = '0;
		case (state)
			FS_IDLE: begin
				rd_op_o = RD_LEN;
				tx_byte = PREAMBLE_BYTE;
			end
			FS_PREAMBLE: begin
				rd_op_o = RD_BYTE;
				tx_byte = (cnt == PREAMBLE_LEN - 1) ? SFD_BYTE : PREAMBLE_BYTE;
			end
			FS_SFD: begin
				rd_op_o = RD_BYTE;
				tx_byte = payload;
			end
			FS_DATA: begin
				rd_op_o = RD_BYTE;
				tx_byte = data_end ? ~reverse_byte(crc[31:24]) : payload;
			end
			FS_FCS: begin
				if (cnt == FCS_LEN)
					rd_op_o = RD_RELEASE;
				else
					tx_byte = ~reverse_byte(crc[31:24]); // msb first
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		tx_data_o <= tx_byte;
		if (state == FS_PREAMBLE && cnt == 0)
			len <= rd_result_i[$bits(pkt_len_t)-1:0]; // RD_LEN from idle
	end

	// --------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FS_IDLE;
			tx_en_o <= 1'b0;
			cnt <= '0;
			addr <= '0;
			crc <= CRC_INIT;
		end else begin
			case (state)
				FS_IDLE: begin
					if (rd_avail_i) begin
						state <= FS_PREAMBLE;
						tx_en_o <= 1'b1;
						cnt <= '0;
						addr <= '0;
						crc <= CRC_INIT;
					end
				end
				FS_PREAMBLE: begin
					if (cnt == PREAMBLE_LEN - 1) begin
						state <= FS_SFD;
						addr <= pkt_len_t'(1);
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				FS_SFD: begin
					state <= FS_DATA;
					addr <= addr + 1'b1;
					crc <= next_crc32_d8(payload, crc);
				end
				FS_DATA: begin
					if (data_end) begin
						state <= FS_FCS;
						cnt <= 4'd1;
						crc <= crc << 8;
					end else begin
						addr <= addr + 1'b1;
						crc <= next_crc32_d8(payload, crc);
					end
				end
				FS_FCS: begin
					if (cnt == FCS_LEN) begin
						state <= FS_GAP;
						tx_en_o <= 1'b0;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
						crc <= crc << 8;
					end
				end
				FS_GAP: begin
					if (cnt == IFG_CYCLES - 1)
						state <= FS_IDLE;
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= FS_IDLE;
			endcase
		end
	end

endmodule

/* logic/rx_deframer.sv */
module rx_deframer (
	input  logic clock,
	input  logic reset,
	input  host_pkg::byte_t rx_data_i,
	input  logic rx_dv_i,
	input  logic rx_er_i,
	output host_pkg::wr_op_t wr_op_o,
	output host_pkg::pkt_len_t wr_addr_o,
	output host_pkg::byte_t wr_data_o,
	input  host_pkg::result_t wr_result_i
);
	import host_pkg::*;
	import eth_pkg::*;

	frame_state_t state;
	logic [2:0] cnt; // preamble bytes, then commit steps
	pkt_len_t addr;
	logic [31:0] crc;
	logic [31:0] crc_next;
	logic in_frame;
	logic line_bad;

	assign crc_next = next_crc32_d8(rx_data_i, crc);
	assign in_frame = state inside {FS_PREAMBLE, FS_SFD, FS_DATA};
	assign line_bad = !rx_dv_i || rx_er_i;

	always_ff @(posedge clock) begin
		if (state == FS_DATA) begin
			wr_addr_o <= addr;
			wr_data_o <= rx_data_i;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FS_IDLE;
			wr_op_o <= WR_NONE;
			cnt <= '0;
			addr <= '0;
			crc <= CRC_INIT;
		end else begin
			wr_op_o <= WR_NONE;
			if (in_frame && line_bad) begin
				wr_op_o <= WR_CLEAR; // drop what was stored
				state <= FS_IDLE;
			end else begin
				case (state)
					FS_IDLE: begin
						if (!line_bad && rx_data_i == PREAMBLE_BYTE) begin
							state <= FS_PREAMBLE;
							cnt <= 3'd1;
						end
					end
					FS_PREAMBLE: begin
						if (rx_data_i != PREAMBLE_BYTE) begin
							wr_op_o <= WR_CLEAR;
							state <= FS_IDLE;
						end else if (cnt == PREAMBLE_LEN - 1) begin
							state <= FS_SFD;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					FS_SFD: begin
						if (rx_data_i == SFD_BYTE) begin
							state <= FS_DATA;
							addr <= '0;
							crc <= CRC_INIT;
						end else begin
							wr_op_o <= WR_CLEAR;
							state <= FS_IDLE;
						end
					end
					FS_DATA: begin
						if (crc_next == CRC_RESIDUE) begin
							wr_op_o <= WR_BYTE; // last fcs byte, trimmed later
							state <= FS_COMMIT;
							cnt <= '0;
						end else if (addr == MAX_LEN - 1) begin
							wr_op_o <= WR_CLEAR; // too long
							state <= FS_IDLE;
						end else begin
							wr_op_o <= WR_BYTE;
							addr <= addr + 1'b1;
							crc <= crc_next;
						end
					end
					// trim, commit, wait for result, check it
					FS_COMMIT: begin
						cnt <= cnt + 1'b1;
						case (cnt)
							3'd0: wr_op_o <= WR_TRIM;
							3'd1: wr_op_o <= WR_COMMIT;
							3'd3: begin
								if (wr_result_i != '0)
									wr_op_o <= WR_CLEAR; // ring full
								state <= FS_IDLE;
							end
							default: ;
						endcase
					end
					default: state <= FS_IDLE;
				endcase
			end
		end
	end

endmodule

/* logic/mac_top.sv */
module mac_top (
	input  logic clock,
	input  logic reset,
	input  logic req_i,
	input  host_pkg::host_op_t op_i,
	input  host_pkg::pkt_len_t addr_i,
	input  host_pkg::byte_t value_i,
	output logic ack_o,
	output host_pkg::result_t result_o,
	output host_pkg::byte_t tx_data_o,
	output logic tx_en_o,
	input  host_pkg::byte_t rx_data_i,
	input  logic rx_dv_i,
	input  logic rx_er_i
);
	import host_pkg::*;

	// --------------------------------------------------
	// transmit ring, host writes and framer reads
	wr_op_t tx_wr_op;
	pkt_len_t tx_wr_addr;
	byte_t tx_wr_data;
	result_t tx_wr_result;
	rd_op_t tx_rd_op;
	pkt_len_t tx_rd_addr;
	result_t tx_rd_result;
	logic tx_rd_avail;

	// receive ring, deframer writes and host reads
	wr_op_t rx_wr_op;
	pkt_len_t rx_wr_addr;
	byte_t rx_wr_data;
	result_t rx_wr_result;
	rd_op_t rx_rd_op;
	pkt_len_t rx_rd_addr;
	result_t rx_rd_result;

	host_port u_host_port (
		.clock, .reset,
		.req_i, .op_i, .addr_i, .value_i, .ack_o, .result_o,
		.tx_wr_op_o(tx_wr_op), .tx_wr_addr_o(tx_wr_addr),
		.tx_wr_data_o(tx_wr_data), .tx_wr_result_i(tx_wr_result),
		.rx_rd_op_o(rx_rd_op), .rx_rd_addr_o(rx_rd_addr),
		.rx_rd_result_i(rx_rd_result)
	);

	packet_ring tx_ring (
		.clock, .reset,
		.wr_op_i(tx_wr_op), .wr_addr_i(tx_wr_addr), .wr_data_i(tx_wr_data),
		.wr_result_o(tx_wr_result),
		.rd_op_i(tx_rd_op), .rd_addr_i(tx_rd_addr), .rd_result_o(tx_rd_result),
		.rd_avail_o(tx_rd_avail)
	);

	packet_ring rx_ring (
		.clock, .reset,
		.wr_op_i(rx_wr_op), .wr_addr_i(rx_wr_addr), .wr_data_i(rx_wr_data),
		.wr_result_o(rx_wr_result),
		.rd_op_i(rx_rd_op), .rd_addr_i(rx_rd_addr), .rd_result_o(rx_rd_result),
		.rd_avail_o() // host polls with READ_NEXT instead
	);

	tx_framer u_tx_framer (
		.clock, .reset,
		.rd_avail_i(tx_rd_avail), .rd_op_o(tx_rd_op), .rd_addr_o(tx_rd_addr),
		.rd_result_i(tx_rd_result), .tx_data_o, .tx_en_o
	);

	rx_deframer u_rx_deframer (
		.clock, .reset,
		.rx_data_i, .rx_dv_i, .rx_er_i,
		.wr_op_o(rx_wr_op), .wr_addr_o(rx_wr_addr), .wr_data_o(rx_wr_data),
		.wr_result_i(rx_wr_result)
	);

endmodule

/* bench/mac_tb.sv */
module mac_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import host_pkg::*;
	import eth_pkg::*;

	localparam int TX_PACKETS = 12;
	localparam int WAIT_LIMIT = 2000; // cycles
	localparam int RX_MAX_LEN = MAX_LEN - 4; // payload and fcs share one slot
	localparam int FRAME_GOOD = 0;
	localparam int FRAME_BAD_BYTE = 1;
	localparam int FRAME_CUT = 2;
	localparam int FRAME_ERR = 3;
	localparam int FRAME_BAD_SFD = 4;

	logic clock;
	logic reset;
	logic req;
	host_op_t op;
	pkt_len_t addr;
	byte_t value;
	logic ack;
	result_t result;
	byte_t tx_data;
	logic tx_en;
	byte_t rx_data;
	logic rx_dv;
	logic rx_er;

	integer seed;
	byte_t tx_bytes [$]; // expected transmit payloads, back to back
	pkt_len_t tx_lens [$];
	byte_t rx_bytes [$];
	pkt_len_t rx_lens [$];
	byte_t payload [$]; // frame being injected

	mac_top uut (
		.clock, .reset,
		.req_i(req), .op_i(op), .addr_i(addr), .value_i(value),
		.ack_o(ack), .result_o(result),
		.tx_data_o(tx_data), .tx_en_o(tx_en),
		.rx_data_i(rx_data), .rx_dv_i(rx_dv), .rx_er_i(rx_er)
	);

	always #10 clock = ~clock;

	// --------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
		if (actual !== expected)
			abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_len(input string name, input pkt_len_t expected,
			input pkt_len_t actual);
		if (actual !== expected)
			abort_run($sformatf("MISMATCH %s expected %0d actual %0d", name, expected, actual));
	endtask

	task automatic check_result(input string name, input result_t expected,
			input result_t actual);
		if (actual !== expected)
			abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic tick();
		@(posedge clock);
		#2; // drive and sample point
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// reflected form, 0xedb88320 is the bit-reversed polynomial
	function automatic logic [31:0] crc_update(input logic [31:0] crc, input byte_t b);
		logic [31:0] c;
		c = crc ^ {24'h0, b};
		for (int i = 0; i < 8; i++)
			c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
		return c;
	endfunction

	// --------------------------------------------------
	// four-phase host command
	task automatic host_cmd(input host_op_t o, input pkt_len_t a, input byte_t v,
			output result_t r);
		int n;
		op = o;
		addr = a;
		value = v;
		req = 1'b1;
		n = 0;
		while (ack !== 1'b1) begin
			if (n == WAIT_LIMIT)
				abort_run("host port never raised ack");
			tick();
			n++;
		end
		r = result;
		req = 1'b0;
		n = 0;
		while (ack !== 1'b0) begin
			if (n == WAIT_LIMIT)
				abort_run("host port never dropped ack");
			tick();
			n++;
		end
	endtask

	task automatic write_packets();
		int len;
		result_t r;
		byte_t data [MAX_LEN];
		for (int p = 0; p < TX_PACKETS; p++) begin
			if (p % 2 == 0)
				len = MAX_LEN - rand_below(4);
			else
				len = 8 + rand_below(3); // short one queues behind the long frame
			for (int i = 0; i < len; i++)
				data[i] = byte_t'($random(seed));
			for (int i = len - 1; i >= 0; i--) begin // top address first
				host_cmd(OP_WRITE, pkt_len_t'(i), data[i], r);
				check_result("write byte status", '0, r);
				if (i == len - 1) begin
					host_cmd(OP_WRITE_LEN, '0, '0, r);
					check_len("length after top byte", pkt_len_t'(len), pkt_len_t'(r));
				end
			end
			host_cmd(OP_WRITE, pkt_len_t'(MAX_LEN), 8'hff, r);
			check_result("write past slot end", result_t'(1), r);
			host_cmd(OP_WRITE_LEN, '0, '0, r);
			check_len("packet length", pkt_len_t'(len), pkt_len_t'(r));
			for (int i = 0; i < len; i++)
				tx_bytes.push_back(data[i]);
			tx_lens.push_back(pkt_len_t'(len));
			host_cmd(OP_WRITE_NEXT, '0, '0, r);
			check_result("commit status", '0, r);
		end
	endtask

	task automatic watch_frames();
		int n;
		int cycles;
		pkt_len_t len;
		logic [31:0] crc;
		byte_t b;
		byte_t want [$];
		for (int f = 0; f < TX_PACKETS; f++) begin
			n = 0;
			while (tx_en !== 1'b1) begin
				if (n == WAIT_LIMIT)
					abort_run("transmit frame never started");
				tick();
				n++;
			end
			if (f > 0 && n < IFG_CYCLES + 1)
				abort_run($sformatf("gap before frame %0d only %0d cycles", f, n));
			if (tx_lens.size() == 0)
				abort_run("frame sent with no packet queued");
			len = tx_lens.pop_front();
			want = {};
			crc = 32'hffffffff;
			for (int i = 0; i < PREAMBLE_LEN; i++)
				want.push_back(PREAMBLE_BYTE);
			want.push_back(SFD_BYTE);
			for (int i = 0; i < len; i++) begin
				b = tx_bytes.pop_front();
				want.push_back(b);
				crc = crc_update(crc, b);
			end
			crc = ~crc;
			for (int i = 0; i < FCS_LEN; i++)
				want.push_back(crc[8*i +: 8]); // low byte on the wire first
			cycles = 0;
			while (tx_en === 1'b1) begin
				if (cycles == want.size())
					abort_run($sformatf("tx_en_o stays high past frame %0d", f));
				check_byte($sformatf("frame %0d byte %0d", f, cycles), want[cycles], tx_data);
				cycles++;
				tick();
			end
			check_len($sformatf("frame %0d cycles", f),
				pkt_len_t'(PREAMBLE_LEN + 1 + FCS_LEN + int'(len)), pkt_len_t'(cycles));
		end
	endtask

	// --------------------------------------------------
	// receive side
	task automatic drive_rx(input byte_t d, input logic dv, input logic er);
		rx_data = d;
		rx_dv = dv;
		rx_er = er;
		tick();
	endtask

	task automatic make_payload(input int len, input logic keep);
		byte_t b;
		payload = {};
		for (int i = 0; i < len; i++) begin
			b = byte_t'($random(seed));
			payload.push_back(b);
			if (keep)
				rx_bytes.push_back(b);
		end
		if (keep)
			rx_lens.push_back(pkt_len_t'(len));
	endtask

	task automatic inject_frame(input int kind);
		logic [31:0] crc;
		byte_t b;
		int cut;
		crc = 32'hffffffff;
		cut = rand_below(payload.size()); // where a broken frame goes wrong
		for (int i = 0; i < PREAMBLE_LEN; i++)
			drive_rx(PREAMBLE_BYTE, 1'b1, 1'b0);
		drive_rx((kind == FRAME_BAD_SFD) ? 8'hd4 : SFD_BYTE, 1'b1, 1'b0);
		for (int i = 0; i < payload.size(); i++) begin
			crc = crc_update(crc, payload[i]);
			b = payload[i];
			if (i == cut && kind == FRAME_CUT)
				break;
			if (i == cut && kind == FRAME_BAD_BYTE)
				b = b ^ 8'h01;
			drive_rx(b, 1'b1, (i == cut && kind == FRAME_ERR));
		end
		crc = ~crc;
		if (kind != FRAME_CUT) begin
			for (int i = 0; i < FCS_LEN; i++)
				drive_rx(crc[8*i +: 8], 1'b1, 1'b0);
		end
		repeat (IFG_CYCLES) drive_rx(8'h00, 1'b0, 1'b0);
	endtask

	task automatic read_packet();
		result_t r;
		pkt_len_t len;
		if (rx_lens.size() == 0)
			abort_run("no receive packet left in the model");
		len = rx_lens.pop_front();
		host_cmd(OP_READ_LEN, '0, '0, r);
		check_len("rx packet length", len, pkt_len_t'(r));
		for (int i = 0; i < len; i++) begin
			host_cmd(OP_READ, pkt_len_t'(i), '0, r);
			check_byte($sformatf("rx byte %0d", i), rx_bytes.pop_front(), byte_t'(r));
		end
		host_cmd(OP_READ, len, '0, r);
		check_result("read past length", '0, r);
		host_cmd(OP_READ_NEXT, '0, '0, r);
		check_result("release status", '0, r);
	endtask

	// --------------------------------------------------
	initial begin
		result_t r;
		seed = 32'hae6f08c8;
		clock = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		op = OP_READ;
		addr = '0;
		value = '0;
		rx_data = '0;
		rx_dv = 1'b0;
		rx_er = 1'b0;
		repeat (5) @(posedge clock);
		#2;
		reset = 1'b0;
		if (ack !== 1'b0 || tx_en !== 1'b0)
			abort_run("ack_o or tx_en_o not low after reset");
		check_result("result after reset", '0, result);
		tick();

		fork
			write_packets();
			watch_frames();
		join

		make_payload(1 + rand_below(RX_MAX_LEN), 1'b1);
		inject_frame(FRAME_GOOD);
		read_packet();

		for (int k = FRAME_BAD_BYTE; k <= FRAME_BAD_SFD; k++) begin
			make_payload(1 + rand_below(RX_MAX_LEN), 1'b0);
			inject_frame(k);
		end
		host_cmd(OP_READ_NEXT, '0, '0, r);
		check_result("release after broken frames", result_t'(1), r);

		// last frame meets a full ring
		for (int k = 0; k < RING_DEPTH; k++) begin
			make_payload(1 + rand_below(RX_MAX_LEN), k < RING_DEPTH - 1);
			inject_frame(FRAME_GOOD);
		end
		for (int k = 0; k < RING_DEPTH - 1; k++)
			read_packet();
		host_cmd(OP_READ_NEXT, '0, '0, r);
		check_result("release on drained ring", result_t'(1), r);

		$display("=== PASS ===");
		$finish;
	end

endmodule

/* sim.f */
logic/eth_pkg.sv
logic/host_pkg.sv
logic/packet_ring.sv
logic/host_port.sv
logic/tx_framer.sv
logic/rx_deframer.sv
logic/mac_top.sv
bench/mac_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the model, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module mac_tb -f sim.f -o mac_sim \
	&& out="$(./obj_dir/mac_sim)"; echo "$out"; \
	echo "$out" | grep -qF "=== PASS ===" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
